// File: verilog/riscv_isa_pkg.sv
////////////////////////////////////////////////////////////
// RV32I encoding definitions for the decode stage
// Trimmed opcode classes, fn3 codes, field widths
// and register read-port indices
////////////////////////////////////////////////////////////
`default_nettype none

package riscv_isa_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_class_w = 5;
    localparam int fn3_w = 3;

    // Register file read ports
    localparam int read_ports = 2;
    localparam int rs1_idx = 0;
    localparam int rs2_idx = 1;

    typedef logic [xlen-1:0] instr_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [fn3_w-1:0] fn3_t;

    // Opcode bits [6:2], the low two bits are always 2'b11
    typedef enum logic [opcode_class_w-1:0] {
        op_load      = 5'b00000,
        op_arith_imm = 5'b00100,
        op_auipc     = 5'b00101,
        op_store     = 5'b01000,
        op_arith     = 5'b01100,
        op_lui       = 5'b01101,
        op_branch    = 5'b11000,
        op_jalr      = 5'b11001,
        op_jal       = 5'b11011
    } opcode_class_t;

    // Arith and branch codes overlap, so no enum here
    localparam fn3_t fn3_add_sub = 3'b000;
    localparam fn3_t fn3_sll     = 3'b001;
    localparam fn3_t fn3_slt     = 3'b010;
    localparam fn3_t fn3_sltu    = 3'b011;
    localparam fn3_t fn3_xor     = 3'b100;
    localparam fn3_t fn3_sra     = 3'b101;
    localparam fn3_t fn3_or      = 3'b110;
    localparam fn3_t fn3_and     = 3'b111;
    localparam fn3_t fn3_bltu    = 3'b110;
    localparam fn3_t fn3_bgeu    = 3'b111;

endpackage

`default_nettype wire

// File: verilog/issue_pkg.sv
////////////////////////////////////////////////////////////
// Issue-side structures
// Unit indices, ALU selectors, decode and issue packets,
// register data and the per-unit operand bundles
////////////////////////////////////////////////////////////
`default_nettype none

package issue_pkg;

    localparam int num_units = 3;
    localparam int unit_alu = 0;
    localparam int unit_br = 1;
    localparam int unit_ls = 2;

    typedef logic [num_units-1:0] unit_vec_t;

    typedef enum logic [1:0] {
        alu_constant,
        alu_add_sub,
        alu_slt,
        alu_shift
    } alu_op_t;

    typedef enum logic [1:0] {
        alu_logic_add,
        alu_logic_xor,
        alu_logic_or,
        alu_logic_and
    } alu_logic_op_t;

    ////////////////////////////////////////////////////////////
    // Fetch to decode
    typedef struct packed {
        logic valid;
        logic [riscv_isa_pkg::xlen-1:0] pc;
        riscv_isa_pkg::instr_t instruction;
    } decode_pkt_t;

    typedef struct packed {
        unit_vec_t unit_needed;
        logic [riscv_isa_pkg::read_ports-1:0] uses_rs;
        riscv_isa_pkg::reg_addr_t [riscv_isa_pkg::read_ports-1:0] rs_addr;
        riscv_isa_pkg::fn3_t fn3;
        riscv_isa_pkg::instr_t instruction;
        alu_op_t alu_op;
        alu_logic_op_t alu_logic_op;
        logic alu_subtract;
        logic alu_imm_type;
        // pc+4, pc+imm or imm
        logic [riscv_isa_pkg::xlen-1:0] constant;
        logic [20:0] pc_offset;
        logic jal;
        logic jalr;
        logic br_signed;
        logic [11:0] ls_offset;
        logic load;
        logic store;
    } decoded_t;

    typedef struct packed {
        decoded_t dec;
        logic [riscv_isa_pkg::xlen-1:0] pc;
    } issue_pkt_t;

    typedef struct packed {
        logic [riscv_isa_pkg::read_ports-1:0][riscv_isa_pkg::xlen-1:0] data;
    } rf_data_t;

    ////////////////////////////////////////////////////////////
    // Unit operand bundles
    typedef struct packed {
        logic [riscv_isa_pkg::xlen:0] in1;
        logic [riscv_isa_pkg::xlen:0] in2;
        logic [4:0] shift_amount;
        logic lshift;
        logic arith;
        logic [riscv_isa_pkg::xlen-1:0] shifter_in;
        logic [riscv_isa_pkg::xlen-1:0] constant_adder;
        logic subtract;
        alu_logic_op_t logic_op;
        alu_op_t alu_op;
    } alu_inputs_t;

    typedef struct packed {
        logic [riscv_isa_pkg::xlen:0] rs1;
        logic [riscv_isa_pkg::xlen:0] rs2;
        riscv_isa_pkg::fn3_t fn3;
        logic [20:0] pc_offset;
        logic jal;
        logic jalr;
        logic jal_jalr;
        logic [riscv_isa_pkg::xlen-1:0] issue_pc;
        logic [riscv_isa_pkg::xlen-1:0] pc_p4;
    } branch_inputs_t;

    typedef struct packed {
        logic [11:0] offset;
        logic load;
        logic store;
        riscv_isa_pkg::fn3_t fn3;
        logic [riscv_isa_pkg::xlen-1:0] rs1;
        logic [riscv_isa_pkg::xlen-1:0] rs2;
    } ls_inputs_t;

endpackage

`default_nettype wire

// File: verilog/opcode_decoder.sv
////////////////////////////////////////////////////////////
// Opcode decoder
// Unit choice, source register use and unit controls
// for one fetched instruction, purely combinational
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
    input  issue_pkg::decode_pkt_t decode_i,
    output issue_pkg::decoded_t    decoded_o
);
    import riscv_isa_pkg::*;
    import issue_pkg::*;

    instr_t instr;
    opcode_class_t opc;
    fn3_t fn3;
    logic [19:0] jal_imm;
    logic [11:0] jalr_imm;
    logic [11:0] br_imm;

    assign instr = decode_i.instruction;
    assign opc = opcode_class_t'(instr[6:2]);
    assign fn3 = instr[14:12];

    assign jal_imm = {instr[31], instr[19:12], instr[20], instr[30:21]};
    assign jalr_imm = instr[31:20];
    assign br_imm = {instr[31], instr[7], instr[30:25], instr[11:8]};

    always_comb begin
        decoded_o = '0;
        decoded_o.instruction = instr;
        decoded_o.fn3 = fn3;
        decoded_o.rs_addr[rs1_idx] = instr[19:15];
        decoded_o.rs_addr[rs2_idx] = instr[24:20];

        // Stores forward their data, so rs2 is not a hazard for them
        decoded_o.uses_rs[rs1_idx] = opc inside {op_jalr, op_branch, op_load, op_store,
                                                 op_arith_imm, op_arith};
        decoded_o.uses_rs[rs2_idx] = opc inside {op_branch, op_arith};

        ////////////////////////////////////////////////////////////
        // Unit choice
        decoded_o.unit_needed[unit_br] = opc inside {op_branch, op_jal, op_jalr};
        decoded_o.unit_needed[unit_alu] = opc inside {op_arith, op_arith_imm, op_auipc,
                                                      op_lui, op_jal, op_jalr};
        decoded_o.unit_needed[unit_ls] = opc inside {op_load, op_store};

        ////////////////////////////////////////////////////////////
        // ALU controls
        case (opc) inside
            op_lui, op_auipc, op_jal, op_jalr: decoded_o.alu_op = alu_constant;
            default: begin
                case (fn3)
                    fn3_slt, fn3_sltu: decoded_o.alu_op = alu_slt;
                    fn3_sll, fn3_sra: decoded_o.alu_op = alu_shift;
                    default: decoded_o.alu_op = alu_add_sub;
                endcase
            end
        endcase

        case (fn3)
            fn3_xor: decoded_o.alu_logic_op = alu_logic_xor;
            fn3_or: decoded_o.alu_logic_op = alu_logic_or;
            fn3_and: decoded_o.alu_logic_op = alu_logic_and;
            default: decoded_o.alu_logic_op = alu_logic_add;
        endcase

        // SUB only exists in the register form
        decoded_o.alu_subtract = (fn3 inside {fn3_slt, fn3_sltu}) ||
                                 ((fn3 == fn3_add_sub) && instr[30] && (opc == op_arith));
        decoded_o.alu_imm_type = (opc == op_arith_imm);

        decoded_o.constant = ((opc == op_lui) ? '0 : decode_i.pc) +
                             ((opc inside {op_lui, op_auipc}) ? {instr[31:12], 12'b0} : 32'd4);

        ////////////////////////////////////////////////////////////
        // Branch and load/store offsets
        case (opc)
            op_jal: decoded_o.pc_offset = 21'(signed'({jal_imm, 1'b0}));
            op_jalr: decoded_o.pc_offset = 21'(signed'(jalr_imm));
            default: decoded_o.pc_offset = 21'(signed'({br_imm, 1'b0}));
        endcase
        decoded_o.jal = (opc == op_jal);
        decoded_o.jalr = (opc == op_jalr);
        decoded_o.br_signed = !(fn3 inside {fn3_bltu, fn3_bgeu});

        decoded_o.ls_offset = (opc == op_store) ? {instr[31:25], instr[11:7]} : instr[31:20];
        decoded_o.load = (opc == op_load);
        decoded_o.store = (opc == op_store);
    end

endmodule

`default_nettype wire

// File: verilog/issue_control.sv
////////////////////////////////////////////////////////////
// Issue control
// Issue stage register, operand hazard check,
// single-unit selection and the fetch advance handshake
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module issue_control (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                decode_valid_i,
    input  issue_pkg::decoded_t                 decoded_i,
    input  logic [riscv_isa_pkg::xlen-1:0]      pc_i,
    input  logic [riscv_isa_pkg::read_ports-1:0] rf_inuse_i,
    input  issue_pkg::unit_vec_t                unit_ready_i,
    input  logic                                hold_i,
    input  logic                                flush_i,
    output issue_pkg::issue_pkt_t               issue_o,
    output riscv_isa_pkg::reg_addr_t [riscv_isa_pkg::read_ports-1:0] rf_rs_addr_o,
    output issue_pkg::unit_vec_t                issue_to_o,
    output logic                                instruction_issued_o,
    output logic                                decode_advance_o
);
    import riscv_isa_pkg::*;
    import issue_pkg::*;

    issue_pkt_t issue_r;
    logic stage_valid;
    logic stage_ready;
    logic issue_ok;
    logic [read_ports-1:0] rs_conflict;
    unit_vec_t chosen;

    ////////////////////////////////////////////////////////////
    // Issue stage register
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_valid <= 1'b0;
        end else if (stage_ready) begin
            stage_valid <= decode_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_ready && decode_valid_i) begin
            issue_r.dec <= decoded_i;
            issue_r.pc <= pc_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue decision
    // Only sources the instruction actually reads can block it
    assign rs_conflict = rf_inuse_i & issue_r.dec.uses_rs;

    // Jumps also need the ALU bundle but go to the branch unit only
    always_comb begin
        chosen = '0;
        if (issue_r.dec.unit_needed[unit_br]) begin
            chosen[unit_br] = 1'b1;
        end else if (issue_r.dec.unit_needed[unit_alu]) begin
            chosen[unit_alu] = 1'b1;
        end else if (issue_r.dec.unit_needed[unit_ls]) begin
            chosen[unit_ls] = 1'b1;
        end
    end

    assign issue_ok = stage_valid && !(|rs_conflict) && !hold_i && !flush_i;
    assign issue_to_o = {num_units{issue_ok}} & chosen & unit_ready_i;
    assign instruction_issued_o = |issue_to_o;

    // Empty or draining this cycle
    assign stage_ready = (!stage_valid || instruction_issued_o) && !hold_i;
    assign decode_advance_o = decode_valid_i && stage_ready;

    assign issue_o = issue_r;
    assign rf_rs_addr_o = issue_r.dec.rs_addr;

endmodule

`default_nettype wire

// File: verilog/alu_operand_builder.sv
////////////////////////////////////////////////////////////
// ALU operand builder
// Adder, logic and shifter inputs from the issue stage
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_operand_builder (
    input  issue_pkg::issue_pkt_t  issue_i,
    input  issue_pkg::rf_data_t    rf_data_i,
    output issue_pkg::alu_inputs_t alu_inputs_o
);
    import riscv_isa_pkg::*;
    import issue_pkg::*;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] op2;
    instr_t instr;
    logic signed_ext;

    assign rs1_data = rf_data_i.data[rs1_idx];
    assign rs2_data = rf_data_i.data[rs2_idx];
    assign instr = issue_i.dec.instruction;

    // I-immediate for the immediate forms
    assign op2 = issue_i.dec.alu_imm_type ? {{20{instr[31]}}, instr[31:20]} : rs2_data;

    // Unsigned compare needs a zero top bit
    assign signed_ext = (issue_i.dec.fn3 != fn3_sltu);

    always_comb begin
        alu_inputs_o.in1 = {rs1_data[xlen-1] & signed_ext, rs1_data};
        alu_inputs_o.in2 = {op2[xlen-1] & signed_ext, op2};

        // Shifter
        alu_inputs_o.shift_amount = issue_i.dec.alu_imm_type ?
                                    issue_i.dec.rs_addr[rs2_idx] : rs2_data[4:0];
        alu_inputs_o.lshift = ~issue_i.dec.fn3[2];
        alu_inputs_o.arith = rs1_data[xlen-1] & instr[30];
        alu_inputs_o.shifter_in = rs1_data;

        // LUI, AUIPC and jump link values
        alu_inputs_o.constant_adder = issue_i.dec.constant;

        alu_inputs_o.subtract = issue_i.dec.alu_subtract;
        alu_inputs_o.logic_op = issue_i.dec.alu_logic_op;
        alu_inputs_o.alu_op = issue_i.dec.alu_op;
    end

endmodule

`default_nettype wire

// File: verilog/target_operand_builder.sv
////////////////////////////////////////////////////////////
// Target operand builder
// Branch unit bundle and load/store unit bundle,
// both carrying a registered offset
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module target_operand_builder (
    input  issue_pkg::issue_pkt_t     issue_i,
    input  issue_pkg::rf_data_t       rf_data_i,
    output issue_pkg::branch_inputs_t branch_inputs_o,
    output issue_pkg::ls_inputs_t     ls_inputs_o
);
    import riscv_isa_pkg::*;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    assign rs1_data = rf_data_i.data[rs1_idx];
    assign rs2_data = rf_data_i.data[rs2_idx];

    ////////////////////////////////////////////////////////////
    // Branch unit
    always_comb begin
        // BLTU and BGEU compare with a zero top bit
        branch_inputs_o.rs1 = {rs1_data[xlen-1] & issue_i.dec.br_signed, rs1_data};
        branch_inputs_o.rs2 = {rs2_data[xlen-1] & issue_i.dec.br_signed, rs2_data};
        branch_inputs_o.fn3 = issue_i.dec.fn3;
        branch_inputs_o.pc_offset = issue_i.dec.pc_offset;
        branch_inputs_o.jal = issue_i.dec.jal;
        branch_inputs_o.jalr = issue_i.dec.jalr;
        branch_inputs_o.jal_jalr = issue_i.dec.jal | issue_i.dec.jalr;
        branch_inputs_o.issue_pc = issue_i.pc;
        // Constant is pc+4 for every branch-unit opcode
        branch_inputs_o.pc_p4 = issue_i.dec.constant;
    end

    ////////////////////////////////////////////////////////////
    // Load/store unit
    always_comb begin
        ls_inputs_o.offset = issue_i.dec.ls_offset;
        ls_inputs_o.load = issue_i.dec.load;
        ls_inputs_o.store = issue_i.dec.store;
        ls_inputs_o.fn3 = issue_i.dec.fn3;
        ls_inputs_o.rs1 = rs1_data;
        ls_inputs_o.rs2 = rs2_data;
    end

endmodule

`default_nettype wire

// File: verilog/decode_and_issue.sv
////////////////////////////////////////////////////////////
// Decode and issue stage top level
// Decoder, issue control and the operand builders
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_and_issue (
    input  logic                                clk,
    input  logic                                rst,
    input  issue_pkg::decode_pkt_t              decode_i,
    output logic                                decode_advance_o,
    output riscv_isa_pkg::reg_addr_t [riscv_isa_pkg::read_ports-1:0] rf_rs_addr_o,
    input  logic [riscv_isa_pkg::read_ports-1:0] rf_inuse_i,
    input  issue_pkg::rf_data_t                 rf_data_i,
    input  issue_pkg::unit_vec_t                unit_ready_i,
    input  logic                                hold_i,
    input  logic                                flush_i,
    output issue_pkg::unit_vec_t                issue_to_o,
    output logic                                instruction_issued_o,
    output issue_pkg::alu_inputs_t              alu_inputs_o,
    output issue_pkg::branch_inputs_t           branch_inputs_o,
    output issue_pkg::ls_inputs_t               ls_inputs_o
);
    import issue_pkg::*;

    decoded_t decoded;
    issue_pkt_t issue_pkt;

    opcode_decoder u_decoder (
        .decode_i  (decode_i),
        .decoded_o (decoded)
    );

    issue_control u_issue (
        .clk                  (clk),
        .rst                  (rst),
        .decode_valid_i       (decode_i.valid),
        .decoded_i            (decoded),
        .pc_i                 (decode_i.pc),
        .rf_inuse_i           (rf_inuse_i),
        .unit_ready_i         (unit_ready_i),
        .hold_i               (hold_i),
        .flush_i              (flush_i),
        .issue_o              (issue_pkt),
        .rf_rs_addr_o         (rf_rs_addr_o),
        .issue_to_o           (issue_to_o),
        .instruction_issued_o (instruction_issued_o),
        .decode_advance_o     (decode_advance_o)
    );

    alu_operand_builder u_alu_ops (
        .issue_i      (issue_pkt),
        .rf_data_i    (rf_data_i),
        .alu_inputs_o (alu_inputs_o)
    );

    target_operand_builder u_target_ops (
        .issue_i         (issue_pkt),
        .rf_data_i       (rf_data_i),
        .branch_inputs_o (branch_inputs_o),
        .ls_inputs_o     (ls_inputs_o)
    );

endmodule

`default_nettype wire

// File: dv/decode_issue_assertions.sv
////////////////////////////////////////////////////////////
// Concurrent checks on the decode and issue top level
// Occupancy model, unit choice, hazards, back-pressure,
// flush and the three operand bundles at issue
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_issue_assertions (
    input logic                                               clk,
    input logic                                               rst,
    input issue_pkg::decode_pkt_t                             decode_i,
    input logic                                               advance_i,
    input riscv_isa_pkg::reg_addr_t [riscv_isa_pkg::read_ports-1:0] rs_addr_i,
    input logic [riscv_isa_pkg::read_ports-1:0]               inuse_i,
    input issue_pkg::rf_data_t                                rf_data_i,
    input issue_pkg::unit_vec_t                               ready_i,
    input logic                                               hold_i,
    input logic                                               flush_i,
    input issue_pkg::unit_vec_t                               issue_to_i,
    input logic                                               issued_i,
    input issue_pkg::alu_inputs_t                             alu_i,
    input issue_pkg::branch_inputs_t                          br_i,
    input issue_pkg::ls_inputs_t                              ls_i
);
    import riscv_isa_pkg::*;
    import issue_pkg::*;

    int unsigned fail_count = 0;
    decode_pkt_t held;
    logic stage_v;
    logic was_waiting;
    reg_addr_t [read_ports-1:0] addr_prev;
    instr_t ins;
    logic [4:0] opc;
    fn3_t f3;
    logic [xlen-1:0] rs1_d;
    logic [xlen-1:0] rs2_d;
    logic [xlen-1:0] op2;
    unit_vec_t want_unit;
    logic [read_ports-1:0] uses;
    logic alu_form;
    logic alu_need;
    logic sub_want;
    logic ext_alu;
    logic ext_br;
    logic [xlen-1:0] want_const;
    logic [20:0] want_off;
    logic [11:0] want_ls;

    // Stage occupancy and a copy of the accepted instruction
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_v <= 1'b0;
        end else if (decode_i.valid && advance_i) begin
            stage_v <= 1'b1;
        end else if (issued_i) begin
            stage_v <= 1'b0;
        end
        if (decode_i.valid && advance_i) begin
            held <= decode_i;
        end
        was_waiting <= !rst && stage_v && !issued_i && !flush_i;
        addr_prev <= rs_addr_i;
    end

    ////////////////////////////////////////////////////////////
    // Expected values from the RV32I encoding
    always_comb begin
        ins = held.instruction;
        opc = ins[6:2];
        f3 = ins[14:12];
        rs1_d = rf_data_i.data[rs1_idx];
        rs2_d = rf_data_i.data[rs2_idx];
        op2 = (opc == op_arith_imm) ? {{20{ins[31]}}, ins[31:20]} : rs2_d;
        alu_form = (opc == op_arith) || (opc == op_arith_imm);
        alu_need = alu_form || (opc inside {op_lui, op_auipc, op_jal, op_jalr});
        ext_alu = (f3 != fn3_sltu);
        ext_br = !((f3 == fn3_bltu) || (f3 == fn3_bgeu));
        sub_want = (f3 == fn3_slt) || (f3 == fn3_sltu) ||
                   ((opc == op_arith) && (f3 == fn3_add_sub) && ins[30]);
        // Jumps issue to the branch unit only
        want_unit[unit_br] = opc inside {op_branch, op_jal, op_jalr};
        want_unit[unit_alu] = opc inside {op_arith, op_arith_imm, op_auipc, op_lui};
        want_unit[unit_ls] = opc inside {op_load, op_store};
        uses[rs1_idx] = opc inside {op_jalr, op_branch, op_load, op_store, op_arith_imm,
                                    op_arith};
        uses[rs2_idx] = opc inside {op_branch, op_arith};
        case (opc)
            op_lui: want_const = {ins[31:12], 12'h000};
            op_auipc: want_const = held.pc + {ins[31:12], 12'h000};
            default: want_const = held.pc + 32'd4;
        endcase
        case (opc)
            op_jal: want_off = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            op_jalr: want_off = {{9{ins[31]}}, ins[31:20]};
            default: want_off = {{9{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        endcase
        want_ls = (opc == op_store) ? {ins[31:25], ins[11:7]} : ins[31:20];
    end

    ////////////////////////////////////////////////////////////
    // Handshake and hazard rules
    a_issue_rule: assert property (@(posedge clk) disable iff (rst)
        (issued_i || issue_to_i != '0) |->
            issued_i && stage_v && (issue_to_i == want_unit) &&
            !(|(inuse_i & uses)) && !hold_i && !flush_i)
        else begin
            fail_count++;
            $error("issue broke the unit, hazard, hold or flush rule");
        end

    // Free operands and a ready unit mean no waiting
    a_progress: assert property (@(posedge clk) disable iff (rst)
        (stage_v && ((ready_i & want_unit) != '0) && !(|(inuse_i & uses)) &&
         !hold_i && !flush_i) |-> issued_i)
        else begin
            fail_count++;
            $error("instruction waited although its operands and unit were free");
        end

    a_advance: assert property (@(posedge clk) disable iff (rst)
        advance_i == (decode_i.valid && !hold_i && (!stage_v || issued_i)))
        else begin
            fail_count++;
            $error("advance does not follow the stage occupancy");
        end

    a_rs_addr: assert property (@(posedge clk) disable iff (rst)
        stage_v |-> (rs_addr_i[rs1_idx] == ins[19:15]) && (rs_addr_i[rs2_idx] == ins[24:20]) &&
                    (!was_waiting || (rs_addr_i == addr_prev)))
        else begin
            fail_count++;
            $error("source addresses wrong or changed while waiting");
        end

    ////////////////////////////////////////////////////////////
    // Operand bundles at issue
    a_alu_ops: assert property (@(posedge clk) disable iff (rst)
        issued_i |->
            (!alu_form || ((alu_i.in1 == {ext_alu & rs1_d[xlen-1], rs1_d}) &&
                           (alu_i.in2 == {ext_alu & op2[xlen-1], op2}) &&
                           (alu_i.subtract == sub_want))) &&
            (!alu_need || (alu_i.constant_adder == want_const)))
        else begin
            fail_count++;
            $error("ALU operand bundle differs from the instruction");
        end

    a_target_ops: assert property (@(posedge clk) disable iff (rst)
        issued_i |->
            (!want_unit[unit_br] || ((br_i.pc_offset == want_off) &&
                                     (br_i.pc_p4 == held.pc + 32'd4) &&
                                     (br_i.issue_pc == held.pc) &&
                                     ((opc != op_branch) ||
                                      ((br_i.rs1 == {ext_br & rs1_d[xlen-1], rs1_d}) &&
                                       (br_i.rs2 == {ext_br & rs2_d[xlen-1], rs2_d}))))) &&
            (!want_unit[unit_ls] || ((ls_i.offset == want_ls) &&
                                     (ls_i.load == (opc == op_load)) &&
                                     (ls_i.store == (opc == op_store)))))
        else begin
            fail_count++;
            $error("branch or load/store operand bundle differs from the instruction");
        end

endmodule

bind decode_and_issue decode_issue_assertions u_chk (
    .clk        (clk),
    .rst        (rst),
    .decode_i   (decode_i),
    .advance_i  (decode_advance_o),
    .rs_addr_i  (rf_rs_addr_o),
    .inuse_i    (rf_inuse_i),
    .rf_data_i  (rf_data_i),
    .ready_i    (unit_ready_i),
    .hold_i     (hold_i),
    .flush_i    (flush_i),
    .issue_to_i (issue_to_o),
    .issued_i   (instruction_issued_o),
    .alu_i      (alu_inputs_o),
    .br_i       (branch_inputs_o),
    .ls_i       (ls_inputs_o)
);

`default_nettype wire

// File: dv/tb_decode_issue.sv
////////////////////////////////////////////////////////////
// Decode and issue testbench
// Clock and reset, random instruction stream, register
// file and unit models, issue count and timeout
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_decode_issue;
    import riscv_isa_pkg::*;
    import issue_pkg::*;

    localparam int num_instr = 2000;
    localparam int min_issues = 1000;
    localparam int max_cycles = 100000;
    // Kept classes plus SYSTEM, which the stage does not support
    localparam logic [4:0] opcodes [10] = '{op_lui, op_auipc, op_jal, op_jalr, op_branch,
                                           op_load, op_store, op_arith_imm, op_arith, 5'b11100};

    logic clk = 1'b0;
    logic rst = 1'b1;
    decode_pkt_t decode = '0;
    logic decode_advance;
    reg_addr_t [read_ports-1:0] rs_addr;
    logic [read_ports-1:0] rf_inuse;
    rf_data_t rf_data;
    logic [31:0] busy_mask = '0;
    unit_vec_t unit_ready = '0;
    logic hold = 1'b0;
    logic flush = 1'b0;
    unit_vec_t issue_to;
    logic issued;
    alu_inputs_t alu_inputs;
    branch_inputs_t branch_inputs;
    ls_inputs_t ls_inputs;
    int sent = 0;
    int issues = 0;

    decode_and_issue dut (
        .clk                  (clk),
        .rst                  (rst),
        .decode_i             (decode),
        .decode_advance_o     (decode_advance),
        .rf_rs_addr_o         (rs_addr),
        .rf_inuse_i           (rf_inuse),
        .rf_data_i            (rf_data),
        .unit_ready_i         (unit_ready),
        .hold_i               (hold),
        .flush_i              (flush),
        .issue_to_o           (issue_to),
        .instruction_issued_o (issued),
        .alu_inputs_o         (alu_inputs),
        .branch_inputs_o      (branch_inputs),
        .ls_inputs_o          (ls_inputs)
    );

    function automatic instr_t random_instruction();
        instr_t word;
        word = $urandom();
        return {word[31:7], opcodes[$urandom_range(9)], 2'b11};
    endfunction

    initial begin
        forever #10 clk = ~clk;
    end

    // Register file, address in the top bits of every byte
    // so that x16..x31 read as negative values
    always_comb begin
        for (int i = 0; i < read_ports; i++) begin
            rf_data.data[i] = {4{rs_addr[i], rs_addr[i][4:2]}};
            rf_inuse[i] = busy_mask[rs_addr[i]] && (rs_addr[i] != '0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Fetch, unit and control models
    always @(posedge clk) begin
        if (!rst) begin
            if (decode.valid && decode_advance) begin
                sent <= sent + 1;
            end
            if (issued) begin
                issues <= issues + 1;
            end
            if (!decode.valid || decode_advance) begin
                decode.valid <= ($urandom_range(7) != 0);
                decode.pc <= $urandom() & 32'hffff_fffc;
                decode.instruction <= random_instruction();
            end
            // About one register in eight busy
            busy_mask <= $urandom() & $urandom() & $urandom();
            unit_ready <= ($urandom_range(7) == 0) ? unit_vec_t'($urandom()) : '1;
            hold <= ($urandom_range(15) == 0);
            flush <= ($urandom_range(19) == 0);
        end
    end

    always @(negedge clk) begin
        if (dut.u_chk.fail_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "a concurrent assertion on the DUT failed");
        end
    end

    initial begin
        int cycles;
        logic timed_out;
        void'($urandom(32'h4885_a62b));
        cycles = 0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // Until the whole stream is accepted
        while ((sent < num_instr) && !timed_out) begin
            @(posedge clk);
            cycles++;
            timed_out = (cycles > max_cycles);
        end
        if (timed_out) begin
            $display("Timeout: only %0d of %0d instructions were accepted", sent, num_instr);
            $display("Simulation failed");
            $fatal(1, "the stage stopped accepting instructions");
        end else if (issues < min_issues) begin
            $display("ERROR: test issue_count expected >= %0d actual %0d", min_issues, issues);
            $display("Simulation failed");
            $fatal(1, "too few instructions issued");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
verilog/riscv_isa_pkg.sv
verilog/issue_pkg.sv
verilog/opcode_decoder.sv
verilog/issue_control.sv
verilog/alu_operand_builder.sv
verilog/target_operand_builder.sv
verilog/decode_and_issue.sv
dv/decode_issue_assertions.sv
dv/tb_decode_issue.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_issue
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
